/* bu_cfg.svh */
/*
 * Build-time configuration of the branch unit and its predictor
 * Included by the package and by every module that sizes a port
 * or a table from these values
 */
`ifndef BU_CFG_SVH
`define BU_CFG_SVH

// Data and address width
`define BU_XLEN 32

// Fetch restarts here after reset
`define BU_PC_INIT 32'h0000_0200

// Global history length in branches
`define BU_HIST_BITS 4

// PHT index width for 64 counters
`define BU_PHT_IDX_BITS 6

// Update queue entries, also the resolver's starting credit
`define BU_UPD_DEPTH 2

`endif

/* bu_pkg.sv */
/*
 * Shared types of the branch unit slice
 * Instruction word views, opcode and funct3 codes, exception flags,
 * predictor update and lookup records and the PHT counter
 * Modules refer to these by scoped name
 */
`include "bu_cfg.svh"

package bu_pkg;

  ////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////

  // Plain register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  // Branch immediate scattered over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } insn_sb_t;

  // Jump immediate
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_uj_t;

  typedef union packed {
    insn_r_t  r;
    insn_sb_t sb;
    insn_uj_t uj;
  } insn_u;

  typedef enum logic [6:0] {
    OPC_BRANCH  = 7'b1100011,
    OPC_JAL     = 7'b1101111,
    OPC_JALR    = 7'b1100111,
    OPC_MISCMEM = 7'b0001111
  } opc_e;

  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } br_f3_e;

  // MISC-MEM funct3 of FENCE.I
  localparam logic [2:0] F3_FENCE_I = 3'b001;

  ////////////////////////////////////////
  // Pipeline and predictor records
  ////////////////////////////////////////

  typedef struct packed {
    logic any;
    logic misaligned_insn;
    logic illegal;
  } exc_t;

  typedef struct packed {
    logic  bubble;
    insn_u insn;
  } id_insn_t;

  // Upper bit is the prediction
  typedef logic [1:0] pht_cnt_t;

  // Every counter resets to weakly not taken
  localparam pht_cnt_t PHT_WEAK_NT = 2'd1;

  typedef struct packed {
    logic [`BU_XLEN-1:0]      pc;
    logic [`BU_HIST_BITS-1:0] hist;
    logic                     taken;
  } bp_upd_t;

  typedef struct packed {
    logic [`BU_XLEN-1:0] pc;
  } bp_lookup_t;

endpackage

/* bu_pht_mem.sv */
/*
 * Pattern history table storage
 * Single port of 2-bit counters, write or registered read per cycle,
 * read data valid the cycle after the request. All counters start
 * weakly not taken
 */
`timescale 1ns/10ps
`include "bu_cfg.svh"

module bu_pht_mem #(
  parameter int DEPTH = 1 << `BU_PHT_IDX_BITS
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] idx_i,
  input  bu_pkg::pht_cnt_t         wdata_i,
  output bu_pkg::pht_cnt_t         rdata_o
);

  bu_pkg::pht_cnt_t cnt_q [DEPTH];

  // Counter array
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        cnt_q[i] <= bu_pkg::PHT_WEAK_NT;
      end
    end else if (req_i && we_i) begin
      cnt_q[idx_i] <= wdata_i;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) rdata_o <= cnt_q[idx_i];
  end

endmodule

/* bu_pht_ctrl.sv */
/*
 * PHT port arbiter
 * Queues training updates from the resolver and runs each as a read
 * then a write of the saturating counter, returning one credit per
 * retired entry. Fetch lookups get the port only when no update is
 * queued or running, with the prediction one cycle after acceptance
 */
`timescale 1ns/10ps
`include "bu_cfg.svh"

module bu_pht_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        upd_valid_i,
  input  bu_pkg::bp_upd_t             upd_i,
  output logic                        credit_o,
  input  logic [`BU_HIST_BITS-1:0]    hist_i,
  input  logic                        if_lookup_valid_i,
  input  bu_pkg::bp_lookup_t          if_lookup_i,
  output logic                        if_lookup_ready_o,
  output logic                        if_predict_valid_o,
  output bu_pkg::pht_cnt_t            if_predict_o,
  output logic                        pht_req_o,
  output logic                        pht_we_o,
  output logic [`BU_PHT_IDX_BITS-1:0] pht_idx_o,
  output bu_pkg::pht_cnt_t            pht_wdata_o,
  input  bu_pkg::pht_cnt_t            pht_rdata_i
);

  localparam int D  = `BU_UPD_DEPTH;
  localparam int PW = (D > 1) ? $clog2(D) : 1;
  localparam int CW = $clog2(D + 1);
  localparam int IW = `BU_PHT_IDX_BITS;

  typedef enum logic [1:0] {S_IDLE, S_UPD_RD, S_UPD_WR} state_e;

  bu_pkg::bp_upd_t  fifo_q [D];
  bu_pkg::bp_upd_t  head;
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic [CW-1:0]    fifo_cnt;
  logic             push;
  logic             pop;
  logic             lookup_go;
  state_e           state_q;
  state_e           state_d;
  bu_pkg::pht_cnt_t cnt_next;

  // gshare index from pc word bits xor history
  function automatic logic [IW-1:0] gshare_idx(input logic [`BU_XLEN-1:0] pc,
                                               input logic [`BU_HIST_BITS-1:0] hist);
    return pc[IW+1:2] ^ IW'(hist);
  endfunction

  ////////////////////////////////////////
  // Update queue
  ////////////////////////////////////////

  assign push     = upd_valid_i;
  assign pop      = (state_q == S_UPD_WR);
  assign head     = fifo_q[rd_ptr];
  assign credit_o = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PW'(D - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PW'(D - 1)) ? '0 : rd_ptr + 1'b1;
      fifo_cnt <= fifo_cnt + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) fifo_q[wr_ptr] <= upd_i;
  end

  ////////////////////////////////////////
  // Port sequencing
  ////////////////////////////////////////

  // Updates go first and lookups wait
  assign if_lookup_ready_o = (state_q == S_IDLE) && (fifo_cnt == '0);
  assign lookup_go         = if_lookup_valid_i & if_lookup_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (fifo_cnt != '0) state_d = S_UPD_RD;
      S_UPD_RD: state_d = S_UPD_WR;
      // Chain straight into the next queued entry
      S_UPD_WR: state_d = (fifo_cnt > CW'(1) || push) ? S_UPD_RD : S_IDLE;
      default:  state_d = S_IDLE;
    endcase
  end

  // Saturating counter step
  always_comb begin
    cnt_next = pht_rdata_i;
    if (head.taken && pht_rdata_i != 2'd3) cnt_next = pht_rdata_i + 2'd1;
    else if (!head.taken && pht_rdata_i != 2'd0) cnt_next = pht_rdata_i - 2'd1;
  end

  assign pht_req_o   = lookup_go || (state_q != S_IDLE);
  assign pht_we_o    = (state_q == S_UPD_WR);
  assign pht_idx_o   = (state_q == S_IDLE) ? gshare_idx(if_lookup_i.pc, hist_i)
                                           : gshare_idx(head.pc, head.hist);
  assign pht_wdata_o = cnt_next;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= S_IDLE;
      if_predict_valid_o <= 1'b0;
    end else begin
      state_q            <= state_d;
      if_predict_valid_o <= lookup_go;
    end
  end

  // Lookup read data comes straight from the table
  assign if_predict_o = pht_rdata_i;

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_valid_i |-> fifo_cnt < CW'(D));

endmodule

/* bu_resolve.sv */
/*
 * Branch resolution for the decode stage of a small RV32I pipeline
 * Takes the instruction in decode with its operands and the fetch
 * prediction, registers next PC, pipeline and I-cache flush and the
 * exception flags one cycle later. Keeps the global history and sends
 * PHT training updates while credits remain
 */
`timescale 1ns/10ps
`include "bu_cfg.svh"

module bu_resolve (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     ex_stall_i,
  input  logic                     st_flush_i,
  input  logic                     younger_exc_i,
  input  logic [`BU_XLEN-1:0]      id_pc_i,
  input  logic [`BU_XLEN-1:0]      opa_i,
  input  logic [`BU_XLEN-1:0]      opb_i,
  input  bu_pkg::id_insn_t         id_insn_i,
  input  bu_pkg::pht_cnt_t         id_bp_predict_i,
  input  bu_pkg::exc_t             id_exc_i,
  input  logic                     du_stall_i,
  input  logic                     du_flush_i,
  input  logic                     du_we_pc_i,
  input  logic [`BU_XLEN-1:0]      du_pc_i,
  input  logic                     credit_i,
  output logic [`BU_XLEN-1:0]      bu_nxt_pc_o,
  output logic                     bu_flush_o,
  output logic                     bu_cacheflush_o,
  output bu_pkg::exc_t             bu_exceptions_o,
  output logic                     upd_valid_o,
  output bu_pkg::bp_upd_t          upd_o,
  output logic [`BU_HIST_BITS-1:0] hist_o
);

  localparam int CW = $clog2(`BU_UPD_DEPTH + 1);
  // Without RVC every instruction is one word
  localparam logic [`BU_XLEN-1:0] INSN_BYTES = 4;

  bu_pkg::insn_u            insn;
  logic [`BU_XLEN-1:0]      imm_sb;
  logic [`BU_XLEN-1:0]      imm_uj;
  logic [`BU_XLEN-1:0]      nxt_pc;
  logic [`BU_XLEN-1:0]      du_nxt_pc;
  logic                     btaken;
  logic                     bp_update;
  logic                     pipeflush;
  logic                     cacheflush;
  logic                     is_xfer;
  logic                     misaligned;
  logic                     du_we_pc_q;
  logic                     du_wrote_pc;
  logic                     send;
  logic [CW-1:0]            credit_cnt;
  logic [`BU_HIST_BITS-1:0] hist_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign insn = id_insn_i.insn;

  // Sign-extended branch and jump offsets
  assign imm_sb = {{(`BU_XLEN-12){insn.sb.imm12}}, insn.sb.imm11,
                   insn.sb.imm10_5, insn.sb.imm4_1, 1'b0};
  assign imm_uj = {{(`BU_XLEN-20){insn.uj.imm20}}, insn.uj.imm19_12,
                   insn.uj.imm11, insn.uj.imm10_1, 1'b0};

  always_comb begin
    btaken     = 1'b0;
    bp_update  = 1'b0;
    pipeflush  = 1'b0;
    cacheflush = 1'b0;
    is_xfer    = 1'b0;
    nxt_pc     = id_pc_i + INSN_BYTES;
    if (!id_insn_i.bubble) begin
      case (insn.r.opcode)
        bu_pkg::OPC_BRANCH: begin
          is_xfer   = 1'b1;
          bp_update = 1'b1;
          case (insn.sb.funct3)
            bu_pkg::F3_BEQ:  btaken = (opa_i == opb_i);
            bu_pkg::F3_BNE:  btaken = (opa_i != opb_i);
            bu_pkg::F3_BLT:  btaken = ($signed(opa_i) < $signed(opb_i));
            bu_pkg::F3_BGE:  btaken = ($signed(opa_i) >= $signed(opb_i));
            bu_pkg::F3_BLTU: btaken = (opa_i < opb_i);
            bu_pkg::F3_BGEU: btaken = (opa_i >= opb_i);
            default:         bp_update = 1'b0;
          endcase
          // Mispredict when outcome and predicted direction disagree
          pipeflush = btaken ^ id_bp_predict_i[1];
          if (btaken) nxt_pc = id_pc_i + imm_sb;
        end
        bu_pkg::OPC_JAL: begin
          is_xfer   = 1'b1;
          btaken    = 1'b1;
          // Fetch already followed a predicted-taken jump
          pipeflush = ~id_bp_predict_i[1];
          nxt_pc    = id_pc_i + imm_uj;
        end
        bu_pkg::OPC_JALR: begin
          is_xfer   = 1'b1;
          btaken    = 1'b1;
          pipeflush = 1'b1;
          nxt_pc    = (opa_i + opb_i) & ~`BU_XLEN'(1);
        end
        bu_pkg::OPC_MISCMEM: begin
          if (insn.r.funct3 == bu_pkg::F3_FENCE_I) begin
            pipeflush  = 1'b1;
            cacheflush = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Exceptions
  ////////////////////////////////////////

  assign misaligned = id_exc_i.misaligned_insn | (is_xfer & (|nxt_pc[1:0]));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bu_exceptions_o <= '0;
    end else if (!ex_stall_i) begin
      // Own flush or a fault further down kills this instruction
      if (bu_flush_o || st_flush_i || younger_exc_i) begin
        bu_exceptions_o <= '0;
      end else if (!du_stall_i) begin
        bu_exceptions_o.any             <= id_exc_i.any | misaligned;
        bu_exceptions_o.misaligned_insn <= misaligned;
        bu_exceptions_o.illegal         <= id_exc_i.illegal;
      end
    end
  end

  ////////////////////////////////////////
  // Debug PC write
  ////////////////////////////////////////

  // Write is remembered until the debug stall drops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      du_we_pc_q  <= 1'b0;
      du_wrote_pc <= 1'b0;
    end else begin
      du_we_pc_q  <= du_we_pc_i;
      du_wrote_pc <= du_we_pc_i | (du_wrote_pc & du_stall_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (du_we_pc_i) du_nxt_pc <= du_pc_i;
  end

  ////////////////////////////////////////
  // Next PC, flush, history, credits
  ////////////////////////////////////////

  // Out of credit the update is simply lost
  assign send = bp_update & ~ex_stall_i & ~du_wrote_pc & (credit_cnt != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bu_flush_o      <= 1'b1;
      bu_cacheflush_o <= 1'b0;
      bu_nxt_pc_o     <= `BU_PC_INIT;
      hist_q          <= '0;
      upd_valid_o     <= 1'b0;
      credit_cnt      <= CW'(`BU_UPD_DEPTH);
    end else begin
      credit_cnt  <= credit_cnt + CW'(credit_i) - CW'(send);
      upd_valid_o <= send;
      if (!ex_stall_i) begin
        if (du_wrote_pc) begin
          // Flush only in the cycle the debug value lands
          bu_flush_o      <= du_we_pc_q;
          bu_cacheflush_o <= 1'b0;
          bu_nxt_pc_o     <= du_nxt_pc;
        end else begin
          bu_flush_o      <= pipeflush & ~du_stall_i & ~du_flush_i;
          bu_cacheflush_o <= cacheflush & ~du_stall_i & ~du_flush_i;
          bu_nxt_pc_o     <= nxt_pc;
          // History shifts even when the update is dropped
          if (bp_update) hist_q <= {hist_q[`BU_HIST_BITS-2:0], btaken};
        end
      end
    end
  end

  // Update carries the history seen before this branch
  always_ff @(posedge clk_i) begin
    if (send) begin
      upd_o.pc    <= id_pc_i;
      upd_o.hist  <= hist_q;
      upd_o.taken <= btaken;
    end
  end

  assign hist_o = hist_q;

  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_cnt <= CW'(`BU_UPD_DEPTH));

  a_cacheflush_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bu_cacheflush_o |-> bu_flush_o);

endmodule

/* bu_top.sv */
/*
 * Branch unit with gshare predictor
 * Resolver, PHT arbiter and PHT storage wired together. Decode, debug
 * and fetch lookup signals are the external ports
 */
`timescale 1ns/10ps
`include "bu_cfg.svh"

module bu_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                ex_stall_i,
  input  logic                st_flush_i,
  input  logic                younger_exc_i,
  input  logic [`BU_XLEN-1:0] id_pc_i,
  input  logic [`BU_XLEN-1:0] opa_i,
  input  logic [`BU_XLEN-1:0] opb_i,
  input  bu_pkg::id_insn_t    id_insn_i,
  input  bu_pkg::pht_cnt_t    id_bp_predict_i,
  input  bu_pkg::exc_t        id_exc_i,
  input  logic                du_stall_i,
  input  logic                du_flush_i,
  input  logic                du_we_pc_i,
  input  logic [`BU_XLEN-1:0] du_pc_i,
  output logic [`BU_XLEN-1:0] bu_nxt_pc_o,
  output logic                bu_flush_o,
  output logic                bu_cacheflush_o,
  output bu_pkg::exc_t        bu_exceptions_o,
  input  logic                if_lookup_valid_i,
  input  bu_pkg::bp_lookup_t  if_lookup_i,
  output logic                if_lookup_ready_o,
  output logic                if_predict_valid_o,
  output bu_pkg::pht_cnt_t    if_predict_o
);

  // Resolver to arbiter
  logic                        upd_valid;
  bu_pkg::bp_upd_t             upd;
  logic                        credit;
  logic [`BU_HIST_BITS-1:0]    hist;
  // Arbiter to table
  logic                        pht_req;
  logic                        pht_we;
  logic [`BU_PHT_IDX_BITS-1:0] pht_idx;
  bu_pkg::pht_cnt_t            pht_wdata;
  bu_pkg::pht_cnt_t            pht_rdata;

  bu_resolve i_resolve (
    .clk_i, .rst_ni, .ex_stall_i, .st_flush_i, .younger_exc_i,
    .id_pc_i, .opa_i, .opb_i, .id_insn_i, .id_bp_predict_i, .id_exc_i,
    .du_stall_i, .du_flush_i, .du_we_pc_i, .du_pc_i,
    .credit_i        (credit),
    .bu_nxt_pc_o, .bu_flush_o, .bu_cacheflush_o, .bu_exceptions_o,
    .upd_valid_o     (upd_valid),
    .upd_o           (upd),
    .hist_o          (hist)
  );

  bu_pht_ctrl i_pht_ctrl (
    .clk_i, .rst_ni,
    .upd_valid_i     (upd_valid),
    .upd_i           (upd),
    .credit_o        (credit),
    .hist_i          (hist),
    .if_lookup_valid_i, .if_lookup_i, .if_lookup_ready_o,
    .if_predict_valid_o, .if_predict_o,
    .pht_req_o       (pht_req),
    .pht_we_o        (pht_we),
    .pht_idx_o       (pht_idx),
    .pht_wdata_o     (pht_wdata),
    .pht_rdata_i     (pht_rdata)
  );

  bu_pht_mem #(
    .DEPTH (1 << `BU_PHT_IDX_BITS)
  ) i_pht_mem (
    .clk_i, .rst_ni,
    .req_i   (pht_req),
    .we_i    (pht_we),
    .idx_i   (pht_idx),
    .wdata_i (pht_wdata),
    .rdata_o (pht_rdata)
  );

endmodule

/* bu_tb_model.svh */
/*
 * Reference model for the branch unit testbench
 * Instruction encoding, branch resolution, global history, a shadow
 * PHT and the compare tasks. Included inside the testbench module
 */
`ifndef BU_TB_MODEL_SVH
`define BU_TB_MODEL_SVH

// Model state
logic [`BU_HIST_BITS-1:0] m_hist;
bu_pkg::pht_cnt_t         m_pht [1 << `BU_PHT_IDX_BITS];
int                       errors;

// RV32I encodings straight from the spec
function automatic logic [31:0] enc_insn(input int kind, input logic [2:0] f3,
                                         input logic [31:0] imm);
  case (kind)
    K_BR:    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    K_JALR:  return {12'd0, 5'd1, 3'b000, 5'd1, 7'b1100111};
    default: return {12'd0, 5'd0, 3'b001, 5'd0, 7'b0001111};
  endcase
endfunction

function automatic logic br_taken(input logic [2:0] f3, input logic [31:0] a, b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

// gshare index from pc word bits xor history
function automatic logic [`BU_PHT_IDX_BITS-1:0] pht_index(input logic [31:0] pc,
                                                         input logic [`BU_HIST_BITS-1:0] h);
  return pc[`BU_PHT_IDX_BITS+1:2] ^ `BU_PHT_IDX_BITS'(h);
endfunction

task automatic model_resolve(input int kind, input logic [2:0] f3,
                             input logic [31:0] imm, pc, a, b,
                             input bu_pkg::pht_cnt_t pred,
                             output logic [31:0] nxt, output logic flush, cflush,
                             output logic mis, taken);
  taken  = 1'b0;
  flush  = 1'b0;
  cflush = 1'b0;
  nxt    = pc + 32'd4;
  case (kind)
    K_BR: begin
      taken = br_taken(f3, a, b);
      flush = taken ^ pred[1];
      if (taken) nxt = pc + imm;
    end
    K_JAL: begin
      taken = 1'b1;
      flush = ~pred[1];
      nxt   = pc + imm;
    end
    K_JALR: begin
      taken = 1'b1;
      flush = 1'b1;
      nxt   = (a + b) & ~32'd1;
    end
    default: begin
      flush  = 1'b1;
      cflush = 1'b1;
    end
  endcase
  mis = (kind != K_FENCEI) && (nxt[1:0] != 2'b00);
endtask

// Saturating counter step, then history shift
task automatic model_train(input logic [31:0] pc, input logic taken);
  logic [`BU_PHT_IDX_BITS-1:0] idx;
  idx = pht_index(pc, m_hist);
  if (taken && m_pht[idx] != 2'd3) m_pht[idx] = m_pht[idx] + 2'd1;
  else if (!taken && m_pht[idx] != 2'd0) m_pht[idx] = m_pht[idx] - 2'd1;
  m_hist = {m_hist[`BU_HIST_BITS-2:0], taken};
endtask

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_word(input string name, input logic [`BU_XLEN-1:0] exp, act);
  if (exp !== act) begin
    errors++;
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, act);
  if (exp !== act) begin
    errors++;
    $display("mismatch %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic check_exc(input string name, input bu_pkg::exc_t exp, act);
  if (exp !== act) begin
    errors++;
    $display("mismatch %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic check_cnt(input string name, input bu_pkg::pht_cnt_t exp, act);
  if (exp !== act) begin
    errors++;
    $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

`endif

/* bu_tb.sv */
/*
 * Testbench for the branch unit with gshare predictor
 * Random branches, jumps, FENCE.I, exceptions, stall and debug writes
 * are checked against the included model, then predictor training and
 * lookup contention. Seeded random stimulus, bounded run time
 */
`timescale 1ns/10ps
`include "bu_cfg.svh"

module bu_tb;

  localparam int K_BR = 0;
  localparam int K_JAL = 1;
  localparam int K_JALR = 2;
  localparam int K_FENCEI = 3;
  localparam logic [2:0] F3S [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  // Test lengths
  localparam int SETTLE = 4;
  localparam int N_BR = 40, N_JMP = 30, N_EXC = 12, N_STALL = 6, N_DBG = 6;
  localparam int N_TRAIN = 24, N_LOOK = 12, N_CONT = 200;
  localparam int EST = 20 + (N_BR + N_JMP + N_EXC + N_TRAIN) * (SETTLE + 2)
                     + N_STALL * (SETTLE + 6) + N_DBG * (SETTLE + 3)
                     + N_LOOK * (SETTLE + 5) + N_CONT + 20;
  localparam int LIMIT = EST * 12 / 10;

  logic clk_i = 1'b0, rst_ni, ex_stall_i, st_flush_i, younger_exc_i;
  logic [`BU_XLEN-1:0] id_pc_i, opa_i, opb_i, du_pc_i, bu_nxt_pc_o;
  bu_pkg::id_insn_t id_insn_i;
  bu_pkg::pht_cnt_t id_bp_predict_i, if_predict_o;
  bu_pkg::exc_t id_exc_i, bu_exceptions_o;
  logic du_stall_i, du_flush_i, du_we_pc_i, bu_flush_o, bu_cacheflush_o;
  logic if_lookup_valid_i, if_lookup_ready_o, if_predict_valid_o;
  bu_pkg::bp_lookup_t if_lookup_i;
  // Handshake monitor state
  int cycles = 0, pending = 0;
  logic pred_due = 1'b0, acc_now = 1'b0;

  `include "bu_tb_model.svh"

  bu_top i_bu_top (.*);

  always #4 clk_i = ~clk_i;

  // One prediction per accepted lookup and none accepted with updates queued
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_bit("predict valid", pred_due, if_predict_valid_o);
      acc_now = if_lookup_valid_i && if_lookup_ready_o;
      if (acc_now && pending != 0) begin
        errors++;
        $display("lookup accepted while %0d updates were pending", pending);
      end
      pred_due = acc_now;
      pending  = pending + int'(i_bu_top.upd_valid) - int'(i_bu_top.credit);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Drive one instruction, check its registered result, then idle
  task automatic run_insn(input string name, input int kind, input logic [2:0] f3,
                          input logic [31:0] imm, pc, a, b, input bu_pkg::pht_cnt_t pred,
                          input logic kill_y, kill_s);
    logic [31:0] nxt;
    logic flush, cflush, mis, taken;
    bu_pkg::exc_t exc;
    model_resolve(kind, f3, imm, pc, a, b, pred, nxt, flush, cflush, mis, taken);
    exc = '0;
    if (!kill_y && !kill_s) exc = '{any: mis, misaligned_insn: mis, illegal: 1'b0};
    @(posedge clk_i);
    #1;
    id_insn_i       = {1'b0, enc_insn(kind, f3, imm)};
    {id_pc_i, opa_i, opb_i, id_bp_predict_i} = {pc, a, b, pred};
    younger_exc_i   = kill_y;
    st_flush_i      = kill_s;
    @(posedge clk_i);
    #1;
    id_insn_i     = {1'b1, 32'h0};
    younger_exc_i = 1'b0;
    st_flush_i    = 1'b0;
    check_word({name, " next pc"}, nxt, bu_nxt_pc_o);
    check_bit({name, " flush"}, flush, bu_flush_o);
    check_bit({name, " cache flush"}, cflush, bu_cacheflush_o);
    check_exc({name, " exceptions"}, exc, bu_exceptions_o);
    if (kind == K_BR) model_train(pc, taken);
    repeat (SETTLE) @(posedge clk_i);
  endtask

  task automatic lookup_pc(input string name, input logic [31:0] pc);
    bu_pkg::pht_cnt_t exp;
    @(posedge clk_i);
    #1;
    if_lookup_valid_i = 1'b1;
    if_lookup_i.pc    = pc;
    do @(negedge clk_i); while (!if_lookup_ready_o);
    exp = m_pht[pht_index(pc, m_hist)];
    @(posedge clk_i);
    #1;
    if_lookup_valid_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_cnt(name, exp, if_predict_o);
  endtask

  function automatic logic [31:0] rnd_pc();
    return ($urandom() % 32'h1000) & ~32'd3;
  endfunction

  initial begin
    logic [31:0] r, a, pcs [4];
    logic [31:0] nxt;
    logic flush, cflush, mis, taken;
    bu_pkg::exc_t exc;
    void'($urandom(32'hbe1d));
    errors = 0;
    m_hist = '0;
    foreach (m_pht[i]) m_pht[i] = 2'd1;
    {rst_ni, ex_stall_i, st_flush_i, younger_exc_i, du_stall_i, du_flush_i} = '0;
    {du_we_pc_i, du_pc_i, if_lookup_valid_i, if_lookup_i} = '0;
    {id_pc_i, opa_i, opb_i, id_bp_predict_i, id_exc_i} = '0;
    id_insn_i = {1'b1, 32'h0};
    repeat (8) @(posedge clk_i);
    #1;
    check_word("reset next pc", `BU_PC_INIT, bu_nxt_pc_o);
    check_bit("reset flush", 1'b1, bu_flush_o);
    check_bit("reset cache flush", 1'b0, bu_cacheflush_o);
    check_exc("reset exceptions", '0, bu_exceptions_o);
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < N_BR; i++) begin
      r = $urandom();
      a = $urandom();
      run_insn("branch", K_BR, F3S[$urandom() % 6], {{19{r[12]}}, r[12:1], 1'b0}, rnd_pc(),
               a, ($urandom() % 4 == 0) ? a : $urandom(), 2'($urandom()), 1'b0, 1'b0);
    end
    for (int i = 0; i < N_JMP; i++) begin
      r = $urandom();
      case (i % 3)
        0: run_insn("jal", K_JAL, 3'b0, {{11{r[20]}}, r[20:1], 1'b0}, rnd_pc(), 0, 0,
                    2'($urandom()), 1'b0, 1'b0);
        1: run_insn("jalr", K_JALR, 3'b0, 0, rnd_pc(), $urandom(), r, 2'd0, 1'b0, 1'b0);
        default: run_insn("fence.i", K_FENCEI, 3'b0, 0, rnd_pc(), 0, 0, 2'd3, 1'b0, 1'b0);
      endcase
    end
    // Misaligned jump targets that a younger fault or a stage flush may kill
    for (int i = 0; i < N_EXC; i++) begin
      run_insn("misaligned", K_JALR, 3'b0, 0, rnd_pc(), $urandom() | 32'd2, 0, 2'd0,
               i % 3 == 1, i % 3 == 2);
    end
    for (int i = 0; i < N_STALL; i++) begin
      r = {{11{1'b0}}, 20'($urandom() & 32'hfff), 1'b0};
      a = rnd_pc();
      model_resolve(K_JAL, 3'b0, r, a, 0, 0, 2'd0, nxt, flush, cflush, mis, taken);
      exc = '{any: mis, misaligned_insn: mis, illegal: 1'b0};
      @(posedge clk_i);
      #1;
      {id_insn_i, id_pc_i, id_bp_predict_i} = {1'b0, enc_insn(K_JAL, 3'b0, r), a, 2'd0};
      @(posedge clk_i);
      #1;
      ex_stall_i = 1'b1;
      id_insn_i  = {1'b0, enc_insn(K_FENCEI, 3'b0, 0)};
      repeat (3) begin
        @(posedge clk_i);
        #1;
        check_word("stall next pc", nxt, bu_nxt_pc_o);
        check_bit("stall flush", flush, bu_flush_o);
        check_bit("stall cache flush", cflush, bu_cacheflush_o);
        check_exc("stall exceptions", exc, bu_exceptions_o);
      end
      {ex_stall_i, id_insn_i} = {1'b0, 1'b1, 32'h0};
      repeat (SETTLE) @(posedge clk_i);
    end
    for (int i = 0; i < N_DBG; i++) begin
      a = rnd_pc();
      #1;
      {du_we_pc_i, du_pc_i} = {1'b1, a};
      @(posedge clk_i);
      #1;
      du_we_pc_i = 1'b0;
      @(posedge clk_i);
      #1;
      check_word("debug next pc", a, bu_nxt_pc_o);
      check_bit("debug flush", 1'b1, bu_flush_o);
      repeat (SETTLE) @(posedge clk_i);
    end
    // Training at a few well spaced branch PCs so nothing is dropped
    foreach (pcs[i]) pcs[i] = rnd_pc();
    for (int i = 0; i < N_TRAIN; i++) begin
      a = $urandom();
      run_insn("train", K_BR, 3'b000, 32'd16, pcs[i % 4], a,
               ($urandom() % 4 != 0) ? a : ~a, 2'd1, 1'b0, 1'b0);
      if (i % 2 == 1) lookup_pc("predict", pcs[$urandom() % 4]);
    end
    // Lookups overlapping a branch burst check the protocol only
    for (int i = 0; i < N_CONT; i++) begin
      @(posedge clk_i);
      #1;
      id_insn_i = {($urandom() % 2 == 0), enc_insn(K_BR, F3S[$urandom() % 6], 32'd8)};
      {id_pc_i, opa_i, opb_i} = {rnd_pc(), 32'($urandom() % 4), 32'($urandom() % 4)};
      if (!if_lookup_valid_i || acc_now) begin
        if_lookup_valid_i = ($urandom() % 2 == 0);
        if_lookup_i.pc    = rnd_pc();
      end
    end
    @(posedge clk_i);
    #1;
    id_insn_i = {1'b1, 32'h0};
    // A request still waiting stays valid until it is taken
    while (if_lookup_valid_i && !acc_now) begin
      @(posedge clk_i);
      #1;
    end
    if_lookup_valid_i = 1'b0;
    repeat (12) @(posedge clk_i);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* bu_top.f */
+incdir+.
bu_pkg.sv
bu_pht_mem.sv
bu_pht_ctrl.sv
bu_resolve.sv
bu_top.sv
bu_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := bu_tb
FILELIST := bu_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
